// ==== coder/jls_bit_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_bit_packer import jls_coding_pkg::*, jls_stream_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire code_t i_code,
    output stream_word_t o_word,
    output logic       o_flush_done     // one pulse when empty after eoi
);

    logic [63:0] acc;        // msb aligned bit queue
    logic [6:0]  fill_cnt;   // bits held, stuffed zeros included
    logic        flushing;
    logic [63:0] acc_in;
    logic [6:0]  fill_in;
    logic [63:0] acc_out;
    logic [7:0]  byte_hi;
    logic [7:0]  byte_lo;
    logic [6:0]  used;       // bits taken by one word, 14..16
    logic        emit;

    // -------------------------------------------------------------------------
    // append, then cut one stuffed word off the top
    // -------------------------------------------------------------------------
    always_comb begin
        acc_in  = acc;
        fill_in = fill_cnt;
        if (i_code.valid) begin
            acc_in  = acc | ({i_code.bits, 32'd0} >> fill_cnt);
            fill_in = fill_cnt + 7'(i_code.count);
        end
        byte_hi = acc_in[63:56];
        acc_out = acc_in << 8;
        if (byte_hi == 8'hff) acc_out = acc_out >> 1;   // zero bit after ff
        byte_lo = acc_out[63:56];
        acc_out = acc_out << 8;
        if (byte_lo == 8'hff) acc_out = acc_out >> 1;   // carries into next word
        used = 7'd16 - 7'(byte_hi == 8'hff) - 7'(byte_lo == 8'hff);
        // full word, or padded leftovers at end of image
        emit = (fill_in >= 7'd16) || (flushing && fill_in != '0);
    end

    always_ff @(posedge clk) begin
        o_word.data <= {byte_hi, byte_lo};
        o_word.last <= 1'b0;                // framer owns the end of frame
        if (reset) begin
            acc          <= '0;
            fill_cnt     <= '0;
            flushing     <= 1'b0;
            o_word.valid <= 1'b0;
            o_flush_done <= 1'b0;
        end else begin
            o_word.valid <= emit;
            o_flush_done <= flushing && (fill_in == '0);
            if (i_code.valid && i_code.eoi) begin
                flushing <= 1'b1;
            end else if (fill_in == '0) begin
                flushing <= 1'b0;
            end
            if (emit) begin
                acc      <= acc_out;
                // padded flush word may take more than is held
                fill_cnt <= (fill_in > used) ? fill_in - used : '0;
            end else begin
                acc      <= acc_in;
                fill_cnt <= fill_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== coder/jls_golomb_coder.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_golomb_coder import jls_coding_pkg::*; #(
    parameter int GOLOMB_K = 2   // 0..7
) (
    input  wire          clk,
    input  wire          reset,
    input  wire mapped_t i_map,
    output code_t        o_code
);

    localparam logic [7:0] REM_MASK = 8'((1 << GOLOMB_K) - 1);

    logic [7:0]               q;      // unary part
    logic [8:0]               tail;   // the one bit and what follows it
    logic [5:0]               len;
    logic [MAX_CODE_BITS-1:0] bits;

    always_comb begin
        q = i_map.merr >> GOLOMB_K;
        if (q < CODE_LIMIT) begin
            tail = 9'((1 << GOLOMB_K) | (i_map.merr & REM_MASK));
            len  = q[5:0] + 6'd1 + 6'(GOLOMB_K);
        end else begin
            // escape code is limit zeros then merr - 1 in qbpp bits
            tail = {1'b1, i_map.merr - 8'd1};
            len  = 6'(CODE_LIMIT + 1 + QBPP);
        end
        // leading zeros come from the shift, msb aligned
        bits = {23'd0, tail} << (6'(MAX_CODE_BITS) - len);
    end

    always_ff @(posedge clk) begin
        o_code.bits  <= bits;
        o_code.count <= len;
        o_code.eoi   <= i_map.eoi;
        if (reset) begin
            o_code.valid <= 1'b0;
        end else begin
            o_code.valid <= i_map.valid;
        end
    end

endmodule

`default_nettype wire

// ==== common/jls_coding_pkg.sv ====
`default_nettype none

package jls_coding_pkg;

    typedef logic [7:0] pixel_t;    // 8-bit grey sample

    // -------------------------------------------------------------------------
    // coding constants
    // -------------------------------------------------------------------------
    localparam int QBPP          = 8;   // bits per escaped sample
    localparam int CODE_LIMIT    = 23;  // longest zero run of the unary prefix
    localparam int MAX_CODE_BITS = 32;  // escape code is 23 + 1 + 8

    // scan tracker to neighbour cache
    typedef struct packed {
        logic   valid;
        logic   first_col;
        logic   first_row;
        logic   last_col;
        logic   eoi;        // last pixel of the image
        pixel_t x;
    } scan_flags_t;

    // neighbour cache to residual mapper
    typedef struct packed {
        logic   valid;
        logic   eoi;
        pixel_t x;
        pixel_t a;          // left
        pixel_t b;          // above
        pixel_t c;          // upper left
    } neighbors_t;

    // residual mapper to golomb coder
    typedef struct packed {
        logic       valid;
        logic       eoi;
        logic [7:0] merr;   // non-negative mapped error
    } mapped_t;

    // golomb coder to bit packer
    typedef struct packed {
        logic                     valid;
        logic                     eoi;
        logic [MAX_CODE_BITS-1:0] bits;   // msb aligned
        logic [5:0]               count;  // 1..32 valid bits
    } code_t;

endpackage

`default_nettype wire

// ==== common/jls_stream_pkg.sv ====
`default_nettype none

package jls_stream_pkg;

    // -------------------------------------------------------------------------
    // markers and header layout
    // -------------------------------------------------------------------------
    localparam int          HEADER_WORDS = 13;
    localparam logic [15:0] MARKER_SOI   = 16'hffd8;
    localparam logic [15:0] MARKER_SOS   = 16'hffda;
    localparam logic [15:0] MARKER_EOI   = 16'hffd9;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_DATA,
        ST_FLUSH,
        ST_FOOTER
    } framer_state_t;

    // packer and framer output word
    typedef struct packed {
        logic        valid;
        logic        last;
        logic [15:0] data;
    } stream_word_t;

    // header word by index with the real image sizes
    function automatic logic [15:0] header_word(input logic [3:0] idx,
                                                input logic [15:0] width,
                                                input logic [15:0] height);
        case (idx)
            4'd0:    return MARKER_SOI;
            4'd1:    return 16'h00ff;   // start of the SOF55 marker
            4'd2:    return 16'hf700;
            4'd3:    return 16'h0b08;   // frame length low byte, 8 bit precision
            4'd4:    return height;
            4'd5:    return width;
            4'd6:    return 16'h0101;   // one component, id 1
            4'd7:    return 16'h1100;   // no subsampling
            4'd8:    return MARKER_SOS;
            4'd9:    return 16'h0008;   // scan header length
            4'd10:   return 16'h0101;
            default: return 16'h0000;   // near 0, no interleave, no transform
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== flist.f ====
common/jls_coding_pkg.sv
common/jls_stream_pkg.sv
predict/jls_scan_tracker.sv
predict/jls_neighbor_cache.sv
predict/jls_residual_mapper.sv
coder/jls_golomb_coder.sv
coder/jls_bit_packer.sv
source/jls_stream_framer.sv
source/jls_encoder_top.sv
tb/jls_encoder_assert.sv
tb/tb_jls_encoder.sv

// ==== predict/jls_neighbor_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_neighbor_cache import jls_coding_pkg::*; #(
    parameter int WIDTH_BITS = 10
) (
    input  wire              clk,
    input  wire              reset,
    input  wire scan_flags_t i_scan,
    output neighbors_t       o_nbr
);

    pixel_t                line_mem [2**WIDTH_BITS];  // previous row
    logic [WIDTH_BITS-1:0] col;                       // own column count
    pixel_t                left_x;                    // previous pixel
    pixel_t                prev_b;                    // previous b, becomes c
    pixel_t                row_b0;                    // b at column 0 of this row
    pixel_t                up;
    pixel_t                a_n;
    pixel_t                c_n;

    // -------------------------------------------------------------------------
    // neighbour select
    // -------------------------------------------------------------------------
    always_comb begin
        up  = i_scan.first_row ? '0 : line_mem[col];  // read before the write below
        a_n = i_scan.first_col ? up : left_x;
        if (i_scan.first_row) begin
            c_n = '0;
        end else if (i_scan.first_col) begin
            c_n = row_b0;                            // b of the row above
        end else begin
            c_n = prev_b;
        end
    end

    // line buffer and context registers
    always_ff @(posedge clk) begin
        if (i_scan.valid) begin
            line_mem[col] <= i_scan.x;
            left_x        <= i_scan.x;
            prev_b        <= up;
            if (i_scan.first_col) row_b0 <= up;
        end
    end

    always_ff @(posedge clk) begin
        o_nbr.x   <= i_scan.x;
        o_nbr.a   <= a_n;
        o_nbr.b   <= up;
        o_nbr.c   <= c_n;
        o_nbr.eoi <= i_scan.eoi;
        if (reset) begin
            o_nbr.valid <= 1'b0;
            col         <= '0;
        end else begin
            o_nbr.valid <= i_scan.valid;
            if (i_scan.valid) begin
                col <= i_scan.last_col ? '0 : col + 1'b1;  // wrap at row end
            end
        end
    end

endmodule

`default_nettype wire

// ==== predict/jls_residual_mapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_residual_mapper import jls_coding_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire neighbors_t i_nbr,
    output mapped_t         o_map
);

    pixel_t     lo;
    pixel_t     hi;
    pixel_t     pred;
    logic [7:0] err;     // x - pred mod 256, two's complement
    logic [7:0] merr;

    // -------------------------------------------------------------------------
    // median edge predictor
    // -------------------------------------------------------------------------
    always_comb begin
        lo = (i_nbr.a < i_nbr.b) ? i_nbr.a : i_nbr.b;
        hi = (i_nbr.a < i_nbr.b) ? i_nbr.b : i_nbr.a;
        if (i_nbr.c >= hi) begin
            pred = lo;                                  // edge above or left
        end else if (i_nbr.c <= lo) begin
            pred = hi;
        end else begin
            pred = i_nbr.a + i_nbr.b - i_nbr.c;         // stays inside lo..hi
        end
        err = i_nbr.x - pred;                           // wraps into -128..127
        // 2e for e >= 0, -2e-1 = ~2e for e < 0
        merr = err[7] ? ~{err[6:0], 1'b0} : {err[6:0], 1'b0};
    end

    always_ff @(posedge clk) begin
        o_map.merr <= merr;
        o_map.eoi  <= i_nbr.eoi;
        if (reset) begin
            o_map.valid <= 1'b0;
        end else begin
            o_map.valid <= i_nbr.valid;
        end
    end

endmodule

`default_nettype wire

// ==== predict/jls_scan_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_scan_tracker import jls_coding_pkg::*; #(
    parameter int WIDTH_BITS = 10
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_sof,
    input  wire [WIDTH_BITS-1:0] i_w,
    input  wire [WIDTH_BITS-1:0] i_h,
    input  wire                  i_valid,
    input  wire pixel_t          i_pixel,
    output scan_flags_t          o_scan,
    output logic [15:0]          o_width,    // real width for the header
    output logic [15:0]          o_height
);

    logic [WIDTH_BITS-1:0] w_lim;    // latched width - 1
    logic [WIDTH_BITS-1:0] h_lim;
    logic [WIDTH_BITS-1:0] col;
    logic [WIDTH_BITS-1:0] row;
    logic                  last_col;
    logic                  last_row;

    assign last_col = (col == w_lim);
    assign last_row = (row == h_lim);

    // header needs sizes, not limits
    assign o_width  = {{(16-WIDTH_BITS){1'b0}}, w_lim} + 16'd1;
    assign o_height = {{(16-WIDTH_BITS){1'b0}}, h_lim} + 16'd1;

    always_ff @(posedge clk) begin
        // position flags of the pixel being taken
        o_scan.first_col <= (col == '0);
        o_scan.first_row <= (row == '0);
        o_scan.last_col  <= last_col;
        o_scan.eoi       <= last_col && last_row;
        o_scan.x         <= i_pixel;
        if (reset) begin
            o_scan.valid <= 1'b0;
            w_lim        <= '0;
            h_lim        <= '0;
            col          <= '0;
            row          <= '0;
        end else begin
            o_scan.valid <= i_valid;
            if (i_sof) begin
                w_lim <= i_w;           // sizes sampled on sof
                h_lim <= i_h;
                col   <= '0;
                row   <= '0;
            end else if (i_valid) begin
                if (last_col) begin
                    col <= '0;
                    row <= row + 1'b1;  // wraps after eoi until the next sof
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the encoder testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_jls_encoder \
    -f flist.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== source/jls_encoder_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_encoder_top import jls_coding_pkg::*, jls_stream_pkg::*; #(
    parameter int WIDTH_BITS = 10,
    parameter int GOLOMB_K   = 2
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_sof,      // start of image
    input  wire [WIDTH_BITS-1:0] i_w,        // width - 1
    input  wire [WIDTH_BITS-1:0] i_h,        // height - 1
    input  wire                  i_valid,
    input  wire pixel_t          i_pixel,
    output logic                 o_valid,
    output logic [15:0]          o_data,
    output logic                 o_last      // footer word
);

    scan_flags_t  scan;
    neighbors_t   nbr;
    mapped_t      map;
    code_t        code;
    stream_word_t word;
    logic [15:0]  width;
    logic [15:0]  height;
    logic         flush_done;

    // -------------------------------------------------------------------------
    // pixel pipeline
    // -------------------------------------------------------------------------
    jls_scan_tracker #(.WIDTH_BITS(WIDTH_BITS)) u_scan (
        .clk      (clk),
        .reset    (reset),
        .i_sof    (i_sof),
        .i_w      (i_w),
        .i_h      (i_h),
        .i_valid  (i_valid),
        .i_pixel  (i_pixel),
        .o_scan   (scan),
        .o_width  (width),
        .o_height (height)
    );

    jls_neighbor_cache #(.WIDTH_BITS(WIDTH_BITS)) u_cache (
        .clk    (clk),
        .reset  (reset),
        .i_scan (scan),
        .o_nbr  (nbr)
    );

    jls_residual_mapper u_mapper (.clk(clk), .reset(reset), .i_nbr(nbr), .o_map(map));

    jls_golomb_coder #(.GOLOMB_K(GOLOMB_K)) u_coder (
        .clk    (clk),
        .reset  (reset),
        .i_map  (map),
        .o_code (code)
    );

    // -------------------------------------------------------------------------
    // stream side
    // -------------------------------------------------------------------------
    jls_bit_packer u_packer (
        .clk          (clk),
        .reset        (reset),
        .i_code       (code),
        .o_word       (word),
        .o_flush_done (flush_done)
    );

    jls_stream_framer u_framer (
        .clk          (clk),
        .reset        (reset),
        .i_sof        (i_sof),
        .i_width      (width),
        .i_height     (height),
        .i_word       (word),
        .i_flush_done (flush_done),
        .o_valid      (o_valid),
        .o_data       (o_data),
        .o_last       (o_last)
    );

endmodule

`default_nettype wire

// ==== source/jls_stream_framer.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_stream_framer import jls_stream_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire               i_sof,
    input  wire [15:0]        i_width,
    input  wire [15:0]        i_height,
    input  wire stream_word_t i_word,
    input  wire               i_flush_done,
    output logic              o_valid,
    output logic [15:0]       o_data,
    output logic              o_last
);

    framer_state_t state;
    logic [3:0]    hdr_idx;

    always_ff @(posedge clk) begin
        o_valid <= 1'b0;
        o_last  <= 1'b0;
        o_data  <= i_word.data;
        if (reset) begin
            state   <= ST_IDLE;
            hdr_idx <= '0;
        end else if (i_sof) begin
            state   <= ST_HEADER;               // restart from any state
            hdr_idx <= '0;
        end else begin
            case (state)
                ST_HEADER: begin
                    o_valid <= 1'b1;
                    o_data  <= header_word(hdr_idx, i_width, i_height);
                    hdr_idx <= hdr_idx + 4'd1;
                    if (hdr_idx == 4'(HEADER_WORDS - 1)) state <= ST_DATA;
                end
                ST_DATA: begin
                    o_valid <= i_word.valid;    // packed words straight through
                    if (i_flush_done) state <= ST_FLUSH;
                end
                ST_FLUSH: begin                 // packer drained so close the stream
                    o_valid <= 1'b1;
                    o_last  <= 1'b1;
                    o_data  <= MARKER_EOI;
                    state   <= ST_FOOTER;
                end
                ST_FOOTER: state <= ST_IDLE;    // footer sent
                default:   state <= ST_IDLE;    // idle until next sof
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb/jls_encoder_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module jls_encoder_assert (
    input wire       clk,
    input wire       reset,
    input wire [6:0] fill_cnt,
    input wire       word_last,
    input wire       flush_done
);

    int fail_cnt = 0;    // failed assertions so far

    // input rules bound the queue at three words
    fill_bound: assert property (@(posedge clk) disable iff (reset) fill_cnt <= 7'd48)
        else begin fail_cnt++; $error("packer fill count above 48"); end

    // end of frame belongs to the framer
    no_last: assert property (@(posedge clk) disable iff (reset) !word_last)
        else begin fail_cnt++; $error("packer raised last on a word"); end

    done_pulse: assert property (@(posedge clk) disable iff (reset) flush_done |=> !flush_done)
        else begin fail_cnt++; $error("flush done held longer than one cycle"); end

endmodule

bind jls_bit_packer jls_encoder_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .fill_cnt   (fill_cnt),
    .word_last  (o_word.last),
    .flush_done (o_flush_done)
);

`default_nettype wire

// ==== tb/tb_jls_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_jls_encoder;

    localparam int K           = 2;                      // golomb k of the DUT
    localparam int TOTAL_PIX   = 5 + 32 + 24 + 24 + 96 + 18 + 10;
    localparam int CYCLE_LIMIT = 40 * TOTAL_PIX + 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic        i_sof;
    logic [9:0]  i_w;
    logic [9:0]  i_h;
    logic        i_valid;
    logic [7:0]  i_pixel;
    logic        o_valid;
    logic [15:0] o_data;
    logic        o_last;

    int          pix [$];        // raster order pixels of the next image
    logic [15:0] exp_q [$];      // expected output words
    bit          last_q [$];     // expected o_last per word
    string       cur_test = "none";
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          footer_cnt = 0;
    int          word_idx = 0;   // position inside the current stream
    int          sof_cycle = 0;
    int          hdr_start = 0;
    int          hdr_end = 0;
    logic [7:0]  prev_byte = 8'h00;

    jls_encoder_top #(.WIDTH_BITS(10), .GOLOMB_K(K)) UUT (
        .clk     (clk),
        .reset   (reset),
        .i_sof   (i_sof),
        .i_w     (i_w),
        .i_h     (i_h),
        .i_valid (i_valid),
        .i_pixel (i_pixel),
        .o_valid (o_valid),
        .o_data  (o_data),
        .o_last  (o_last)
    );

    always #4 clk = ~clk;        // 8 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: no end of stream after %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;                      // drive just after the edge
    endtask

    task automatic check_value(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic int med_predict(input int a, input int b, input int c);
        int lo;
        int hi;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        if (c >= hi) return lo;
        if (c <= lo) return hi;
        return a + b - c;
    endfunction

    function automatic int map_residual(input int x, input int p);
        int e;
        e = (x - p) & 255;                       // modulo 256
        if (e >= 128) e = e - 256;               // signed range
        return (e >= 0) ? 2 * e : -2 * e - 1;
    endfunction

    task automatic push_word(input logic [15:0] w, input bit last);
        exp_q.push_back(w);
        last_q.push_back(last);
    endtask

    task automatic model_image(input int w, input int h);
        logic [15:0] hdr [13];
        bit          code_q [$];
        bit          stuff_q [$];
        int          a;
        int          b;
        int          c;
        int          m;
        int          esc;
        int          nbits;
        logic [7:0]  cur;
        logic [15:0] word;
        hdr = '{16'hffd8, 16'h00ff, 16'hf700, 16'h0b08, 16'(h), 16'(w), 16'h0101,
                16'h1100, 16'hffda, 16'h0008, 16'h0101, 16'h0000, 16'h0000};
        foreach (hdr[i]) push_word(hdr[i], 1'b0);
        for (int r = 0; r < h; r++) begin
            for (int col = 0; col < w; col++) begin
                b = (r == 0) ? 0 : pix[(r - 1) * w + col];        // above
                a = (col == 0) ? b : pix[r * w + col - 1];        // left
                if (r == 0) c = 0;
                else if (col == 0) c = (r >= 2) ? pix[(r - 2) * w] : 0;
                else c = pix[(r - 1) * w + col - 1];
                m = map_residual(pix[r * w + col], med_predict(a, b, c));
                if ((m >> K) < 23) begin
                    repeat (m >> K) code_q.push_back(1'b0);     // unary part
                    code_q.push_back(1'b1);
                    for (int n = K - 1; n >= 0; n--) code_q.push_back(m[n]);
                end else begin
                    esc = m - 1;                                // escape code
                    repeat (23) code_q.push_back(1'b0);
                    code_q.push_back(1'b1);
                    for (int n = 7; n >= 0; n--) code_q.push_back(esc[n]);
                end
            end
        end
        // zero bit after every ff byte
        cur = 8'h00;
        nbits = 0;
        foreach (code_q[i]) begin
            stuff_q.push_back(code_q[i]);
            cur = {cur[6:0], code_q[i]};
            nbits++;
            if (nbits == 8) begin
                nbits = 0;
                if (cur == 8'hff) begin
                    stuff_q.push_back(1'b0);
                    cur = 8'h00;
                    nbits = 1;
                end
            end
        end
        while (stuff_q.size() % 16 != 0) stuff_q.push_back(1'b0);  // pad
        for (int i = 0; i < stuff_q.size(); i += 16) begin
            for (int j = 0; j < 16; j++) word[15 - j] = stuff_q[i + j];
            push_word(word, 1'b0);
        end
        push_word(16'hffd9, 1'b1);               // footer
    endtask

    // ------------------------------------------------------------------------
    // output collector
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset && o_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error in %s: word %h arrived with nothing expected",
                         cur_test, o_data);
            end else begin
                check_value("word", exp_q.pop_front(), o_data);
                check_value("last", {15'd0, last_q.pop_front()}, {15'd0, o_last});
            end
            if (word_idx == 0) hdr_start = cycle_cnt;
            if (word_idx == 12) hdr_end = cycle_cnt;
            if (word_idx < 13) begin
                prev_byte = 8'h00;
            end else if (!o_last) begin
                // byte after ff must open with a zero
                if (prev_byte == 8'hff) check_value("stuffed bit", 16'd0, {15'd0, o_data[15]});
                if (o_data[15:8] == 8'hff) check_value("stuffed bit", 16'd0, {15'd0, o_data[7]});
                prev_byte = o_data[7:0];
            end
            if (o_last) begin
                footer_cnt++;
                word_idx = 0;
            end else begin
                word_idx++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus and tests
    // ------------------------------------------------------------------------
    task automatic drive_image(input int w, input int h);
        sof_cycle = cycle_cnt;
        i_sof = 1'b1;
        i_w   = 10'(w - 1);
        i_h   = 10'(h - 1);
        tick();
        i_sof = 1'b0;
        repeat (20) tick();                      // header goes out meanwhile
        for (int i = 0; i < w * h; i++) begin
            i_valid = 1'b1;
            i_pixel = 8'(pix[i]);
            tick();
            i_valid = 1'b0;                      // every second cycle
            tick();
        end
    endtask

    task automatic run_image(input int w, input int h);
        int target;
        target = footer_cnt + 1;
        model_image(w, h);
        drive_image(w, h);
        while (footer_cnt < target) @(posedge clk);  // watchdog covers a hang
        #1;
    endtask

    task automatic report_test(input int err0);
        $display("test %s finished with %0d errors", cur_test, errors - err0);
    endtask

    task automatic header_test();
        int err0;
        err0 = errors;
        cur_test = "header";
        pix.delete();
        for (int i = 0; i < 5; i++) pix.push_back(i * 9 + 3);
        run_image(5, 1);
        check_value("header start", 16'd2, 16'(hdr_start - sof_cycle));
        check_value("header span", 16'd12, 16'(hdr_end - hdr_start));
        report_test(err0);
    endtask

    task automatic flat_test();
        int err0;
        err0 = errors;
        cur_test = "flat";
        pix.delete();
        repeat (32) pix.push_back(8'h80);
        run_image(8, 4);
        report_test(err0);
    endtask

    task automatic escape_test();
        int err0;
        err0 = errors;
        cur_test = "escape";
        pix.delete();
        // half scale steps wrap to the largest residual
        for (int i = 0; i < 24; i++) pix.push_back((i % 2) ? 8'h80 : 8'h00);
        run_image(8, 3);
        report_test(err0);
    endtask

    task automatic stuffing_test();
        int err0;
        err0 = errors;
        cur_test = "stuffing";
        pix.delete();
        for (int i = 0; i < 24; i++) pix.push_back(254 - 2 * i);  // merr 3, code 111
        run_image(24, 1);
        report_test(err0);
    endtask

    task automatic random_test();
        int err0;
        err0 = errors;
        cur_test = "random";
        pix.delete();
        repeat (96) pix.push_back(int'($urandom % 256));
        run_image(16, 6);
        report_test(err0);
    endtask

    task automatic back_to_back_test();
        int err0;
        err0 = errors;
        cur_test = "back to back";
        pix.delete();
        for (int i = 0; i < 18; i++) pix.push_back((i * 37 + 11) & 255);
        run_image(6, 3);
        pix.delete();
        repeat (10) pix.push_back(int'($urandom % 256));
        run_image(5, 2);                         // no reset in between
        report_test(err0);
    endtask

    initial begin
        void'($urandom(32'h7347_c444));
        reset   = 1'b1;
        i_sof   = 1'b0;
        i_w     = '0;
        i_h     = '0;
        i_valid = 1'b0;
        i_pixel = '0;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        tick();
        header_test();
        flat_test();
        escape_test();
        stuffing_test();
        random_test();
        back_to_back_test();
        if (exp_q.size() != 0) begin
            errors++;
            $display("error: %0d expected words never arrived", exp_q.size());
        end
        if (UUT.u_packer.u_assert.fail_cnt != 0) begin
            errors += UUT.u_packer.u_assert.fail_cnt;
            $display("error: bit packer assertions failed");
        end
        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
